//--- rsa_testdata.txt
// header: step_count row_count, then the step lines, then the expected row lines
// step: a0 a1 a2 a3 b0 b1 b2 b3 last m0 m1 m2 m3 mode0 mode1 mode2 mode3
// row: row c0 c1 c2 c3 (mode 0 pass, 1 add, 2 sub, 3 reverse sub)
0008 0008
// job 1, every row in pass mode, products wrap at 2^16
0001 0002 0003 0004 0001 0001 0001 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000
0005 0006 0007 0008 0002 0000 0001 0003 0000 0000 0000 0000 0000 0000 0000 0000 0000
0100 0010 0001 0000 0100 0010 0002 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000
0002 0003 0004 0005 0000 0001 0010 ffff 0001 1111 2222 3333 4444 0000 0000 0000 0000
// job 2, rows add sub rsub add
0001 0001 0001 0001 0001 0002 0003 0004 0000 0000 0000 0000 0000 0000 0000 0000 0000
0002 0000 0001 0003 0001 0001 0001 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0003 0000 0001 0005 0000 0002 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000
0001 0001 0002 ffff 0000 0001 0001 0002 0001 fffe 000a 0005 0100 0001 0002 0003 0001
// expected rows of job 1
0000 000b 1003 0226 010e
0001 100e 0105 0058 0021
0002 0111 0017 004c 0015
0003 0014 0009 005c 0017
// expected rows of job 2
0000 0001 0003 0004 0006
0001 0006 fff9 0000 ffff
0002 0003 0000 ffff fffc
0003 0109 0104 0107 0106

//--- project.f
rsa_pkg.sv
pe_mac.sv
sync_adder.sv
pe_array.sv
step_skewer.sv
result_fifo.sv
result_emitter.sv
rsa_top.sv
rsa_top_sva.sv
tb_rsa_top.sv

//--- Bender.yml
package:
  name: rsa

sources:
  - rsa_pkg.sv
  - pe_mac.sv
  - sync_adder.sv
  - pe_array.sv
  - step_skewer.sv
  - result_fifo.sv
  - result_emitter.sv
  - rsa_top.sv
  - target: test
    files:
      - rsa_top_sva.sv
      - tb_rsa_top.sv

//--- tb_rsa_top.sv
`timescale 1ns/1ps

module tb_rsa_top
  import rsa_pkg::*;
();

  logic        clk;
  logic        i_arst_n;
  step_t       i_step;
  logic        i_step_req;
  logic        i_res_ack;
  logic        o_step_ack;
  row_result_t o_res;
  logic        o_res_req;

  // flat word image of the data file
  data_t tv [256];
  int    n_steps      = 0;
  int    n_rows       = 0;
  int    errors       = 0;
  int    rows_got     = 0;
  int    stall_cycles = 0;
  logic  last_acked   = 1'b0;
  logic  loaded       = 1'b0;

  rsa_top dut0 (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_step     (i_step),
    .i_step_req (i_step_req),
    .i_res_ack  (i_res_ack),
    .o_step_ack (o_step_ack),
    .o_res      (o_res),
    .o_res_req  (o_res_req)
  );

  bind rsa_top rsa_top_sva u_rsa_top_sva (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_step     (i_step),
    .i_step_req (i_step_req),
    .o_step_ack (o_step_ack),
    .o_res      (o_res),
    .o_res_req  (o_res_req)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // sample and drive just after the rising edge
  task automatic wait_cycle();
    @(posedge clk);
    #0.5;
  endtask

  // two header words, then 17 words per step line and 5 per row line
  function automatic int step_base(input int idx);
    return 2 + idx * (3 * X + Y + 1);
  endfunction

  function automatic int row_base(input int idx);
    return step_base(n_steps) + idx * (Y + 1);
  endfunction

  task automatic send_step(input int idx);
    step_t s;
    int    base;
    base = step_base(idx);
    for (int i = 0; i < X; i++) begin
      s.a[i]    = tv[base + i];
      s.m[i]    = tv[base + X + Y + 1 + i];
      s.mode[i] = adder_mode_e'(tv[base + 2 * X + Y + 1 + i][1:0]);
    end
    for (int j = 0; j < Y; j++) begin
      s.b[j] = tv[base + X + j];
    end
    s.last     = tv[base + X + Y][0];
    i_step     = s;
    i_step_req = 1'b1;
    wait_cycle();
    // a held-off last step shows up here as extra cycles
    while (!o_step_ack) begin
      if (s.last) begin
        stall_cycles++;
      end
      wait_cycle();
    end
    if (s.last) begin
      last_acked = 1'b1;
    end
    i_step_req = 1'b0;
    wait_cycle();
    while (o_step_ack) begin
      wait_cycle();
    end
  endtask

  task automatic check_row(input row_result_t got);
    int base;
    if (rows_got >= n_rows) begin
      errors++;
      $display("unexpected extra result row with index %0d at %0t", got.row, $time);
    end else begin
      base = row_base(rows_got);
      if (got.row !== tv[base][ROW_W-1:0]) begin
        errors++;
        $display("mismatch at %0t: o_res.row expected %0d got %0d",
                 $time, tv[base][ROW_W-1:0], got.row);
      end
      for (int j = 0; j < Y; j++) begin
        if (got.c[j] !== tv[base + 1 + j]) begin
          errors++;
          $display("mismatch at %0t: o_res.c[%0d] of result %0d expected %h got %h",
                   $time, j, rows_got, tv[base + 1 + j], got.c[j]);
        end
      end
    end
    rows_got++;
  endtask

  // slow random responder on the result side
  initial begin : res_responder
    int          pause;
    row_result_t got;
    i_res_ack = 1'b0;
    void'($urandom(32'hb1f6));
    forever begin
      wait_cycle();
      if (o_res_req && !i_res_ack) begin
        got = o_res;
        check_row(got);
        pause = $urandom % 7;
        repeat (pause) wait_cycle();
        i_res_ack = 1'b1;
        while (o_res_req) begin
          wait_cycle();
        end
        pause = $urandom % 7;
        repeat (pause) wait_cycle();
        i_res_ack = 1'b0;
      end
    end
  end

  // no result may be offered before a job is complete
  initial begin : early_req_watch
    logic reported;
    reported = 1'b0;
    wait (i_arst_n === 1'b1);
    forever begin
      wait_cycle();
      if (o_res_req && !last_acked && !reported) begin
        errors++;
        reported = 1'b1;
        $display("result request raised at %0t before any last step was accepted", $time);
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat ((n_steps + n_rows) * 200) @(posedge clk);
    $display("timeout at %0t: only %0d of %0d result rows arrived", $time, rows_got, n_rows);
    $display("errors: %0d", errors + 1);
    $display("Some tests failed");
    $finish;
  end

  initial begin : main_seq
    i_arst_n   = 1'b0;
    i_step     = '0;
    i_step_req = 1'b0;
    $readmemh("rsa_testdata.txt", tv);
    n_steps = int'(tv[0]);
    n_rows  = int'(tv[1]);
    if (n_steps == 0 || n_rows == 0 || row_base(n_rows) > 256) begin
      errors++;
      $display("test data file is missing, empty or too long");
      n_steps = 0;
      n_rows  = 0;
    end
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    #0.5;
    i_arst_n = 1'b1;
    if (o_step_ack !== 1'b0) begin
      errors++;
      $display("mismatch at %0t: o_step_ack expected 0 got %b", $time, o_step_ack);
    end
    if (o_res_req !== 1'b0) begin
      errors++;
      $display("mismatch at %0t: o_res_req expected 0 got %b", $time, o_res_req);
    end
    for (int s = 0; s < n_steps; s++) begin
      send_step(s);
    end
    while (rows_got < n_rows) begin
      wait_cycle();
    end
    // extra rows would show up here
    repeat (40) wait_cycle();
    if (stall_cycles == 0) begin
      errors++;
      $display("the skewer never held back the ack of a last step");
    end
    $display("errors: %0d, result rows received: %0d of %0d", errors, rows_got, n_rows);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- rsa_top_sva.sv
`timescale 1ns/1ps

module rsa_top_sva
  import rsa_pkg::*;
(
  input logic        clk,
  input logic        i_arst_n,
  input step_t       i_step,
  input logic        i_step_req,
  input logic        o_step_ack,
  input row_result_t o_res,
  input logic        o_res_req
);

  logic       ack_q;
  logic [7:0] job_steps;

  // steps accepted since the previous last step
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ack_q     <= 1'b0;
      job_steps <= '0;
    end else begin
      ack_q <= o_step_ack;
      if (o_step_ack && !ack_q) begin
        job_steps <= i_step.last ? '0 : job_steps + 1'b1;
      end
    end
  end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!i_arst_n)
    $rose(o_step_ack) |-> $past(i_step_req))
    else $error("step ack rose without a step request");

  a_res_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_res_req && $past(o_res_req)) |-> $stable(o_res))
    else $error("result payload changed while the result request was high");

  // the accepted last step closes the job
  a_job_length: assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_step_ack && !ack_q && i_step.last) |-> (int'(job_steps) + 1 >= MIN_JOB_STEPS))
    else $error("job ended with fewer steps than the minimum");

endmodule

//--- rsa_top.sv
`timescale 1ns/1ps

module rsa_top
  import rsa_pkg::*;
(
  input  logic        clk,
  input  logic        i_arst_n,
  input  step_t       i_step,
  input  logic        i_step_req,
  input  logic        i_res_ack,
  output logic        o_step_ack,
  output row_result_t o_res,
  output logic        o_res_req
);

  data_t    [X-1:0]    a_w;
  row_ctl_t [X-1:0]    ctl_w;
  logic     [X-1:0]    ctl_load;
  data_t    [Y-1:0]    b_n;
  logic     [Y-1:0]    cal_en;
  logic     [Y-1:0]    cal_done;
  row_result_t         row;
  logic                row_valid;
  row_result_t         fifo_row;
  logic                fifo_valid;
  logic                pop;
  logic     [FREE_W-1:0] free;

  step_skewer u_step_skewer (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_step     (i_step),
    .i_step_req (i_step_req),
    .i_free     (free),
    .i_row_push (row_valid),
    .o_step_ack (o_step_ack),
    .o_a        (a_w),
    .o_ctl      (ctl_w),
    .o_ctl_load (ctl_load),
    .o_b        (b_n),
    .o_cal_en   (cal_en),
    .o_cal_done (cal_done)
  );

  pe_array u_pe_array (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_a         (a_w),
    .i_ctl       (ctl_w),
    .i_ctl_load  (ctl_load),
    .i_b         (b_n),
    .i_cal_en    (cal_en),
    .i_cal_done  (cal_done),
    .o_row       (row),
    .o_row_valid (row_valid)
  );

  result_fifo u_result_fifo (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_push   (row_valid),
    .i_row    (row),
    .i_pop    (pop),
    .o_row    (fifo_row),
    .o_valid  (fifo_valid),
    .o_free   (free)
  );

  result_emitter u_result_emitter (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_row     (fifo_row),
    .i_valid   (fifo_valid),
    .i_res_ack (i_res_ack),
    .o_pop     (pop),
    .o_res     (o_res),
    .o_res_req (o_res_req)
  );

endmodule

//--- result_emitter.sv
`timescale 1ns/1ps

module result_emitter
  import rsa_pkg::*;
(
  input  logic        clk,
  input  logic        i_arst_n,
  input  row_result_t i_row,
  input  logic        i_valid,
  input  logic        i_res_ack,
  output logic        o_pop,
  output row_result_t o_res,
  output logic        o_res_req
);

  typedef enum logic [1:0] {
    S_IDLE = 2'd0,
    S_REQ  = 2'd1,
    S_REL  = 2'd2
  } emit_state_e;

  emit_state_e state;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: if (i_valid) state <= S_REQ;
        S_REQ:  if (i_res_ack) state <= S_REL;
        // wait for the receiver to release ack
        S_REL:  if (!i_res_ack) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // row held from pop until the next pop
  always_ff @(posedge clk) begin
    if (o_pop) begin
      o_res <= i_row;
    end
  end

  assign o_pop     = (state == S_IDLE) && i_valid;
  assign o_res_req = (state == S_REQ);

endmodule

//--- result_fifo.sv
`timescale 1ns/1ps

module result_fifo
  import rsa_pkg::*;
(
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_push,
  input  row_result_t       i_row,
  input  logic              i_pop,
  output row_result_t       o_row,
  output logic              o_valid,
  output logic [FREE_W-1:0] o_free
);

  row_result_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [FREE_W-1:0] count;

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_row;
    end
  end

  // depth is a power of two so pointers wrap on their own
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign o_row   = mem[rd_ptr];
  assign o_valid = (count != '0);
  assign o_free  = FREE_W'(FIFO_DEPTH) - count;

endmodule

//--- step_skewer.sv
`timescale 1ns/1ps

module step_skewer
  import rsa_pkg::*;
(
  input  logic                  clk,
  input  logic                  i_arst_n,
  input  step_t                 i_step,
  input  logic                  i_step_req,
  input  logic     [FREE_W-1:0] i_free,
  input  logic                  i_row_push,
  output logic                  o_step_ack,
  output data_t    [X-1:0]      o_a,
  output row_ctl_t [X-1:0]      o_ctl,
  output logic     [X-1:0]      o_ctl_load,
  output data_t    [Y-1:0]      o_b,
  output logic     [Y-1:0]      o_cal_en,
  output logic     [Y-1:0]      o_cal_done
);

  typedef struct packed {
    data_t    a;
    row_ctl_t ctl;
    logic     ctl_load;
  } west_lane_t;

  typedef struct packed {
    data_t b;
    logic  cal_en;
    logic  cal_done;
  } north_lane_t;

  west_lane_t  [X-1:0] w_stage;
  north_lane_t [Y-1:0] n_stage;
  logic                can_take;
  logic                accept;
  logic [PEND_W-1:0]   pend_rows;

  // a last step needs room for a whole job and an idle drain path
  assign can_take = !i_step.last || ((i_free >= FREE_W'(X)) && (pend_rows == '0));
  assign accept   = i_step_req && !o_step_ack && can_take;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_step_ack <= 1'b0;
      pend_rows  <= '0;
    end else begin
      if (accept) begin
        o_step_ack <= 1'b1;
      end else if (!i_step_req) begin
        o_step_ack <= 1'b0;
      end
      if (accept && i_step.last) begin
        pend_rows <= PEND_W'(X);
      end else if (i_row_push) begin
        pend_rows <= pend_rows - 1'b1;
      end
    end
  end

  // skew stage zero, loaded in the cycle ack rises
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      w_stage <= '0;
      n_stage <= '0;
    end else begin
      for (int i = 0; i < X; i++) begin
        w_stage[i].ctl_load <= accept && i_step.last;
        if (accept) begin
          w_stage[i].a        <= i_step.a[i];
          w_stage[i].ctl.m    <= i_step.m[i];
          w_stage[i].ctl.mode <= i_step.mode[i];
        end
      end
      for (int j = 0; j < Y; j++) begin
        n_stage[j].cal_en   <= accept;
        n_stage[j].cal_done <= accept && i_step.last;
        if (accept) begin
          n_stage[j].b <= i_step.b[j];
        end
      end
    end
  end

  // row i waits i more cycles
  for (genvar i = 0; i < X; i++) begin : g_west
    west_lane_t w_out;
    if (i == 0) begin : g_direct
      assign w_out = w_stage[i];
    end else begin : g_delay
      west_lane_t dly [i];
      always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
          dly <= '{default: '0};
        end else begin
          dly[0] <= w_stage[i];
          for (int d = 1; d < i; d++) begin
            dly[d] <= dly[d-1];
          end
        end
      end
      assign w_out = dly[i-1];
    end
    assign o_a[i]        = w_out.a;
    assign o_ctl[i]      = w_out.ctl;
    assign o_ctl_load[i] = w_out.ctl_load;
  end

  // column j waits j more cycles
  for (genvar j = 0; j < Y; j++) begin : g_north
    north_lane_t n_out;
    if (j == 0) begin : g_direct
      assign n_out = n_stage[j];
    end else begin : g_delay
      north_lane_t dly [j];
      always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
          dly <= '{default: '0};
        end else begin
          dly[0] <= n_stage[j];
          for (int d = 1; d < j; d++) begin
            dly[d] <= dly[d-1];
          end
        end
      end
      assign n_out = dly[j-1];
    end
    assign o_b[j]        = n_out.b;
    assign o_cal_en[j]   = n_out.cal_en;
    assign o_cal_done[j] = n_out.cal_done;
  end

endmodule

//--- pe_array.sv
`timescale 1ns/1ps

module pe_array
  import rsa_pkg::*;
(
  input  logic                  clk,
  input  logic                  i_arst_n,
  input  data_t       [X-1:0]   i_a,
  input  row_ctl_t    [X-1:0]   i_ctl,
  input  logic        [X-1:0]   i_ctl_load,
  input  data_t       [Y-1:0]   i_b,
  input  logic        [Y-1:0]   i_cal_en,
  input  logic        [Y-1:0]   i_cal_done,
  output row_result_t           o_row,
  output logic                  o_row_valid
);

  // horizontal links, index j is the west side of PE (i,j)
  data_t a_h  [X][Y+1];
  data_t mr_h [X][Y+1];
  logic  mv_h [X][Y+1];
  // vertical links, index i is the north side of PE (i,j)
  data_t b_v  [X+1][Y];
  logic  en_v [X+1][Y];
  logic  dn_v [X+1][Y];

  data_t       [X-1:0] sum;
  logic        [X-1:0] sum_val;
  row_result_t [X-1:0] row_pk;
  logic        [X-1:0] row_full;

  for (genvar i = 0; i < X; i++) begin : g_edge_w
    assign a_h[i][0]  = i_a[i];
    // nothing drains in from the east edge
    assign mr_h[i][Y] = '0;
    assign mv_h[i][Y] = 1'b0;
  end

  for (genvar j = 0; j < Y; j++) begin : g_edge_n
    assign b_v[0][j]  = i_b[j];
    assign en_v[0][j] = i_cal_en[j];
    assign dn_v[0][j] = i_cal_done[j];
  end

  for (genvar i = 0; i < X; i++) begin : g_pe_x
    for (genvar j = 0; j < Y; j++) begin : g_pe_y
      pe_mac u_pe_mac (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_a_w          (a_h[i][j]),
        .i_b_n          (b_v[i][j]),
        .i_cal_en_n     (en_v[i][j]),
        .i_cal_done_n   (dn_v[i][j]),
        .i_mulres_e     (mr_h[i][j+1]),
        .i_mulres_val_e (mv_h[i][j+1]),
        .o_a_e          (a_h[i][j+1]),
        .o_b_s          (b_v[i+1][j]),
        .o_cal_en_s     (en_v[i+1][j]),
        .o_cal_done_s   (dn_v[i+1][j]),
        .o_mulres_w     (mr_h[i][j]),
        .o_mulres_val_w (mv_h[i][j])
      );
    end
  end

  for (genvar i = 0; i < X; i++) begin : g_row
    logic [COL_W-1:0] col_q;
    logic             full_q;
    data_t [Y-1:0]    c_q;

    sync_adder u_sync_adder (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ctl      (i_ctl[i]),
      .i_ctl_load (i_ctl_load[i]),
      .i_c        (mr_h[i][0]),
      .i_c_val    (mv_h[i][0]),
      .o_sum      (sum[i]),
      .o_sum_val  (sum_val[i])
    );

    // drained values leave the west edge in column order
    always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
        col_q  <= '0;
        full_q <= 1'b0;
      end else begin
        full_q <= sum_val[i] && (col_q == COL_W'(Y - 1));
        if (sum_val[i]) begin
          col_q <= (col_q == COL_W'(Y - 1)) ? '0 : col_q + 1'b1;
        end
      end
    end

    always_ff @(posedge clk) begin
      if (sum_val[i]) begin
        c_q[col_q] <= sum[i];
      end
    end

    assign row_full[i]   = full_q;
    assign row_pk[i].row = ROW_W'(i);
    assign row_pk[i].c   = c_q;
  end

  // rows finish on distinct cycles so a plain select is enough
  always_comb begin
    o_row_valid = 1'b0;
    o_row       = '0;
    for (int i = 0; i < X; i++) begin
      if (row_full[i]) begin
        o_row_valid = 1'b1;
        o_row       = row_pk[i];
      end
    end
  end

endmodule

//--- sync_adder.sv
`timescale 1ns/1ps

module sync_adder
  import rsa_pkg::*;
(
  input  logic     clk,
  input  logic     i_arst_n,
  input  row_ctl_t i_ctl,
  input  logic     i_ctl_load,
  input  data_t    i_c,
  input  logic     i_c_val,
  output data_t    o_sum,
  output logic     o_sum_val
);

  row_ctl_t ctl_q;
  data_t    sum_d;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ctl_q     <= '0;
      o_sum_val <= 1'b0;
    end else begin
      if (i_ctl_load) begin
        ctl_q <= i_ctl;
      end
      o_sum_val <= i_c_val;
    end
  end

  // all four modes wrap at 2^16
  always_comb begin
    case (ctl_q.mode)
      MODE_ADD:  sum_d = i_c + ctl_q.m;
      MODE_SUB:  sum_d = i_c - ctl_q.m;
      MODE_RSUB: sum_d = ctl_q.m - i_c;
      default:   sum_d = i_c;
    endcase
  end

  always_ff @(posedge clk) begin
    o_sum <= sum_d;
  end

endmodule

//--- pe_mac.sv
`timescale 1ns/1ps

module pe_mac
  import rsa_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,
  input  data_t i_a_w,
  input  data_t i_b_n,
  input  logic  i_cal_en_n,
  input  logic  i_cal_done_n,
  input  data_t i_mulres_e,
  input  logic  i_mulres_val_e,
  output data_t o_a_e,
  output data_t o_b_s,
  output logic  o_cal_en_s,
  output logic  o_cal_done_s,
  output data_t o_mulres_w,
  output logic  o_mulres_val_w
);

  data_t prod;
  data_t acc;
  logic  done_q;

  // product kept modulo 2^16 like the rest of the datapath
  assign prod = i_a_w * i_b_n;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      acc            <= '0;
      done_q         <= 1'b0;
      o_cal_en_s     <= 1'b0;
      o_cal_done_s   <= 1'b0;
      o_mulres_val_w <= 1'b0;
    end else begin
      o_cal_en_s   <= i_cal_en_n;
      o_cal_done_s <= i_cal_done_n;
      done_q       <= i_cal_done_n;
      if (done_q) begin
        // next job may already be streaming in
        acc            <= i_cal_en_n ? prod : '0;
        o_mulres_val_w <= 1'b1;
      end else begin
        if (i_cal_en_n) begin
          acc <= acc + prod;
        end
        o_mulres_val_w <= i_mulres_val_e;
      end
    end
  end

  always_ff @(posedge clk) begin
    o_a_e      <= i_a_w;
    o_b_s      <= i_b_n;
    o_mulres_w <= done_q ? acc : i_mulres_e;
  end

endmodule

//--- rsa_pkg.sv
package rsa_pkg;

  // array geometry and word size
  localparam int X      = 4;
  localparam int Y      = 4;
  localparam int RSA_DW = 16;

  // shorter jobs would let two drains meet in the west chain
  localparam int MIN_JOB_STEPS = Y;

  // two jobs worth of result rows
  localparam int FIFO_DEPTH = 8;

  localparam int ROW_W  = $clog2(X);
  localparam int COL_W  = $clog2(Y);
  localparam int PTR_W  = $clog2(FIFO_DEPTH);
  localparam int FREE_W = $clog2(FIFO_DEPTH + 1);
  localparam int PEND_W = $clog2(X + 1);

  typedef logic [RSA_DW-1:0] data_t;

  typedef enum logic [1:0] {
    MODE_PASS = 2'd0,
    MODE_ADD  = 2'd1,
    MODE_SUB  = 2'd2,
    MODE_RSUB = 2'd3
  } adder_mode_e;

  typedef struct packed {
    data_t       [X-1:0] a;
    data_t       [Y-1:0] b;
    logic                last;
    data_t       [X-1:0] m;
    adder_mode_e [X-1:0] mode;
  } step_t;

  typedef struct packed {
    data_t       m;
    adder_mode_e mode;
  } row_ctl_t;

  typedef struct packed {
    logic  [ROW_W-1:0] row;
    data_t [Y-1:0]     c;
  } row_result_t;

endpackage
